// ==== run.sh ====
#!/bin/bash
# build the cartridge front end testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --top-module cart_tb \
    -f sources.f --Mdir "$build_dir" -o cart_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/cart_tb_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$log"; then
    exit 1
fi
if ! grep -q "Regression passed" "$log"; then
    echo "no result found in $log"
    exit 1
fi
exit 0

// ==== sources.f ====
+incdir+verilog
verilog/cart_pkg.sv
verilog/bus_demux.sv
verilog/sdc_regs.sv
verilog/cart_data_out.sv
verilog/cart_top.sv
tb/cart_tb.sv

// ==== tb/cart_tb.sv ====
`timescale 1ns/1ps
`include "cart_config.svh"

module cart_tb
    import cart_pkg::*;
();

    localparam int ACCESS_CYCLES  = 50;     // present, strobe, recovery
    localparam int ACCESS_BUDGET  = 200;
    localparam int TIMEOUT_CYCLES = 2 * ACCESS_CYCLES * ACCESS_BUDGET;

    localparam logic [7:0] CTL_MEM = 8'h82;    // merq_n low, iorq_n and m1_n high
    localparam logic [7:0] CTL_IO  = 8'h81;
    localparam logic [7:0] CTL_M1  = 8'h02;

    typedef struct packed {
        logic        en;
        logic        busy;
        logic        tmo;
        logic        crc;
        logic [31:0] sector;
    } sdc_model_t;

    logic       clk108_w;
    logic       ram_enabled_w;
    logic [7:0] mp;
    logic       rd_n;
    logic       wr_n;
    logic       sltsl_n;
    logic [7:0] cd_in;
    logic       sd_ack;
    logic       crc_error;
    logic       timeout_error;
    logic [2:0] msel_n;
    logic [7:0] cd_out;
    logic       datadir;
    logic       sd_req;
    sd_cmd_t    sd_cmd;
    logic       led;

    logic [15:0] cur_addr;    // what the host puts on the mux
    logic [7:0]  cur_ctl;
    sdc_model_t  model;
    logic        hold_ack;
    integer      seed = 32'h7c30f8f5;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    string       name_q[$];
    logic [8:0]  exp_q[$];
    logic [8:0]  got_q[$];
    sd_cmd_t     cmd_log[$];
    sd_cmd_t     exp_cmd_q[$];
    event        rd_done;

    cart_top cart_top_i (.*);

    initial clk108_w = 1'b0;
    always #4 clk108_w = ~clk108_w;

    // board side mux, one byte per select code
    always_comb begin
        case (msel_n)
            3'b110:  mp = cur_addr[7:0];
            3'b101:  mp = cur_addr[15:8];
            3'b011:  mp = cur_ctl;
            default: mp = 8'h00;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // reference model

    function automatic logic [2:0] phase_code(input dot_phase_t ph);
        case (ph)
            PH_LO_SEL, PH_LO_SMP:   phase_code = 3'b110;
            PH_HI_SEL, PH_HI_SMP:   phase_code = 3'b101;
            PH_CTL_SEL, PH_CTL_SMP: phase_code = 3'b011;
            default:                phase_code = 3'b111;
        endcase
    endfunction

    function automatic logic mem_cycle(input logic [7:0] ctl, input logic slot_n);
        mem_cycle = !slot_n && !ctl[`CTL_MERQ_BIT] && ctl[`CTL_IORQ_BIT] && ctl[`CTL_M1_BIT];
    endfunction

    function automatic sd_op_t cmd_op(input logic [7:0] data);
        if (data[0])
            cmd_op = SD_OP_READ;
        else if (data[1])
            cmd_op = SD_OP_WRITE;
        else if (data[7])
            cmd_op = SD_OP_INIT;
        else
            cmd_op = SD_OP_NONE;
    endfunction

    // bit 8 says the cartridge drives the bus
    function automatic logic [8:0] sdc_expect(input logic [15:0] addr, input sdc_model_t st);
        logic [7:0] b;
        case (addr)
            `SDC_ENABLE:        b = {7'b0, st.en};
            `SDC_STATUS:        b = {st.busy, 5'b0, st.tmo, st.crc};
            `SDC_SADDR:         b = st.sector[7:0];
            `SDC_SADDR + 16'd1: b = st.sector[15:8];
            `SDC_SADDR + 16'd2: b = st.sector[23:16];
            `SDC_SADDR + 16'd3: b = st.sector[31:24];
            default:            b = 8'hFF;
        endcase
        sdc_expect = {st.en && addr >= `SDC_ENABLE && addr <= `SDC_END, b};
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // host bus accesses

    // a full frame has to pass before the address is usable
    task automatic present(input logic [15:0] addr, input logic [7:0] ctl);
        @(posedge clk108_w);
        cur_addr <= addr;
        cur_ctl  <= ctl;
        repeat (18) @(posedge clk108_w);
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data,
                             input logic [7:0] ctl, input logic slot_n);
        int idx;
        present(addr, ctl);
        wr_n    <= 1'b0;
        sltsl_n <= slot_n;
        cd_in   <= data;
        if (mem_cycle(ctl, slot_n)) begin
            if (addr == `SDC_ENABLE) begin
                model.en = data[0];
            end else if (model.en && addr <= `SDC_END) begin
                idx = int'(addr - `SDC_SADDR);
                if (addr == `SDC_CMD && !model.busy && cmd_op(data) != SD_OP_NONE) begin
                    model.busy = 1'b1;
                    exp_cmd_q.push_back(sd_cmd_t'({cmd_op(data), model.sector}));
                end else if (addr >= `SDC_SADDR && idx < 4) begin
                    model.sector[8*idx +: 8] = data;
                end
            end
        end
        repeat (16) @(posedge clk108_w);
        wr_n    <= 1'b1;
        sltsl_n <= 1'b1;
        repeat (4) @(posedge clk108_w);
    endtask

    task automatic bus_read(input string name, input logic [15:0] addr,
                            input logic [7:0] ctl, input logic slot_n);
        logic [8:0] expv;
        logic       driven;
        logic [7:0] first;
        present(addr, ctl);
        expv = mem_cycle(ctl, slot_n) ? sdc_expect(addr, model) : 9'h000;
        if (!expv[8])
            expv = 9'h000;    // no drive, byte is don't care
        driven  = 1'b0;
        first   = 8'h00;
        rd_n    <= 1'b0;
        sltsl_n <= slot_n;
        repeat (16) begin
            @(negedge clk108_w);
            if (!datadir && !driven) begin
                driven = 1'b1;
                first  = cd_out;
            end else if (!datadir) begin
                check({name, " held"}, 32'(first), 32'(cd_out));
            end
        end
        @(posedge clk108_w);
        rd_n    <= 1'b1;
        sltsl_n <= 1'b1;
        repeat (8) @(negedge clk108_w);
        if (!datadir) begin
            errors++;
            $display("datadir still low well after the read strobe ended in %s", name);
        end
        name_q.push_back(name);
        exp_q.push_back(expv);
        got_q.push_back({driven, driven ? first : 8'h00});
        -> rd_done;
    endtask

    // wait for ack held with req low, or for the whole handshake to close
    task automatic wait_handshake(input logic ack_held, input string what);
        int n;
        n = 0;
        while (n < 200 && !(ack_held ? (sd_ack && !sd_req) : (!sd_ack && !led))) begin
            @(negedge clk108_w);
            n++;
        end
        if (n == 200) begin
            errors++;
            $display("%s did not happen within 200 cycles", what);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // sd engine model and read compare

    initial begin : sd_engine
        int delay;
        forever begin
            @(negedge clk108_w);
            if (sd_req && !sd_ack) begin
                cmd_log.push_back(sd_cmd);
                delay = 1 + int'($unsigned($random(seed)) % 20);
                repeat (delay) begin
                    @(negedge clk108_w);
                    check("sd_req held until sd_ack", 32'd1, 32'(sd_req));
                end
                @(posedge clk108_w);
                sd_ack <= 1'b1;
                @(negedge clk108_w);
                while (sd_req)
                    @(negedge clk108_w);
                delay = 1 + int'($unsigned($random(seed)) % 20);
                repeat (delay) @(posedge clk108_w);
                while (hold_ack)
                    @(posedge clk108_w);    // test keeps the engine busy
                sd_ack <= 1'b0;
            end
        end
    end

    initial begin : read_compare
        forever begin
            @(rd_done);
            while (name_q.size() > 0)
                check(name_q.pop_front(), 32'(exp_q.pop_front()), 32'(got_q.pop_front()));
        end
    end

    always @(posedge clk108_w) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("%0d checks, %0d errors", checks, errors + 1);
            $display("Regression failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin : main
        logic [7:0] cmds [3];
        dot_phase_t ph;
        sd_cmd_t    got;
        sd_cmd_t    want;
        int         n;
        cmds = '{8'h01, 8'h02, 8'h80};
        ram_enabled_w = 1'b0;
        rd_n          = 1'b1;
        wr_n          = 1'b1;
        sltsl_n       = 1'b1;
        cd_in         = 8'h00;
        sd_ack        = 1'b0;
        crc_error     = 1'b0;
        timeout_error = 1'b0;
        cur_addr      = 16'h0000;
        cur_ctl       = 8'hFF;
        hold_ack      = 1'b0;
        model         = '0;
        repeat (3) @(posedge clk108_w);
        @(negedge clk108_w);
        check("msel_n in reset", 32'h7, 32'(msel_n));
        check("datadir in reset", 32'h1, 32'(datadir));
        check("sd_req in reset", 32'h0, 32'(sd_req));
        check("led in reset", 32'h0, 32'(led));
        @(posedge clk108_w);
        ram_enabled_w <= 1'b1;

        // two frames of the dot sequencer
        n = 0;
        while (msel_n != 3'b110 && n < 10) begin
            @(negedge clk108_w);
            n++;
        end
        for (int i = 0; i < 16; i++) begin
            ph = dot_phase_t'(i[2:0]);
            check($sformatf("msel_n in %s", ph.name()), 32'(phase_code(ph)), 32'(msel_n));
            @(negedge clk108_w);
        end

        bus_read("status while disabled", `SDC_STATUS, CTL_MEM, 1'b0);
        bus_write(`SDC_ENABLE, 8'h01, CTL_MEM, 1'b0);
        bus_read("enable", `SDC_ENABLE, CTL_MEM, 1'b0);

        for (int k = 0; k < 4; k++)
            bus_write(`SDC_SADDR + 16'(k), 8'($random(seed)), CTL_MEM, 1'b0);
        for (int k = 0; k < 4; k++)
            bus_read($sformatf("sector byte %0d", k), `SDC_SADDR + 16'(k), CTL_MEM, 1'b0);
        bus_read("unused window address", 16'h7E40, CTL_MEM, 1'b0);

        for (int k = 0; k < 3; k++) begin
            bus_write(`SDC_SADDR + 16'(k), 8'($random(seed)), CTL_MEM, 1'b0);
            hold_ack = 1'b1;
            bus_write(`SDC_CMD, cmds[k], CTL_MEM, 1'b0);
            @(negedge clk108_w);
            check($sformatf("led busy %0d", k), 32'h1, 32'(led));
            bus_read($sformatf("status busy %0d", k), `SDC_STATUS, CTL_MEM, 1'b0);
            bus_write(`SDC_CMD, 8'h01, CTL_MEM, 1'b0);    // dropped while busy
            hold_ack = 1'b0;
            wait_handshake(1'b0, "handshake close");
            model.busy = 1'b0;
            bus_read($sformatf("status idle %0d", k), `SDC_STATUS, CTL_MEM, 1'b0);
        end

        @(posedge clk108_w);
        crc_error  <= 1'b1;
        model.crc  = 1'b1;
        bus_read("status crc_error", `SDC_STATUS, CTL_MEM, 1'b0);
        @(posedge clk108_w);
        crc_error     <= 1'b0;
        timeout_error <= 1'b1;
        model.crc     = 1'b0;
        model.tmo     = 1'b1;
        bus_read("status timeout_error", `SDC_STATUS, CTL_MEM, 1'b0);

        // busy clears in the middle of this read
        hold_ack = 1'b1;
        bus_write(`SDC_CMD, 8'h80, CTL_MEM, 1'b0);
        wait_handshake(1'b1, "sd_ack with sd_req low");
        fork
            bus_read("status as busy clears", `SDC_STATUS, CTL_MEM, 1'b0);
            begin
                repeat (26) @(posedge clk108_w);
                hold_ack = 1'b0;
            end
        join
        wait_handshake(1'b0, "handshake close");
        model.busy = 1'b0;
        bus_read("status after busy cleared", `SDC_STATUS, CTL_MEM, 1'b0);

        check("sd_req count", exp_cmd_q.size(), cmd_log.size());
        while (exp_cmd_q.size() > 0 && cmd_log.size() > 0) begin
            want = exp_cmd_q.pop_front();
            got  = cmd_log.pop_front();
            check("sd_cmd op", 32'(want.op), 32'(got.op));
            check("sd_cmd sector", want.sector, got.sector);
        end

        // foreign cycles touch nothing
        bus_write(`SDC_SADDR, 8'h5A, CTL_IO, 1'b0);
        bus_write(`SDC_SADDR + 16'd1, 8'hA5, CTL_M1, 1'b0);
        bus_write(`SDC_SADDR + 16'd2, 8'h3C, CTL_MEM, 1'b1);
        bus_write(`SDC_ENABLE, 8'h00, CTL_IO, 1'b0);
        bus_read("io cycle read", `SDC_ENABLE, CTL_IO, 1'b0);
        bus_read("m1 cycle read", `SDC_STATUS, CTL_M1, 1'b0);
        bus_read("other slot read", `SDC_SADDR, CTL_MEM, 1'b1);
        for (int k = 0; k < 3; k++)
            bus_read($sformatf("sector kept %0d", k), `SDC_SADDR + 16'(k), CTL_MEM, 1'b0);
        bus_read("enable kept", `SDC_ENABLE, CTL_MEM, 1'b0);

        repeat (10) @(posedge clk108_w);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== verilog/bus_demux.sv ====
`timescale 1ns/1ps
`include "cart_config.svh"

module bus_demux
    import cart_pkg::*;
(
    input  logic                    clk108_w,
    input  logic                    ram_enabled_w,
    input  logic [`CART_DATA_W-1:0] mp,
    input  logic                    rd_n,
    input  logic                    wr_n,
    input  logic                    sltsl_n,
    input  logic [`CART_DATA_W-1:0] cd_in,
    output logic [2:0]              msel_n,
    output cart_bus_t               bus
);

    dot_phase_t phase_q;
    dot_phase_t phase_d;
    logic [2:0] msel_q;

    logic [`CART_DATA_W-1:0] lo_q;        // staging until the frame closes
    logic [`CART_DATA_W-1:0] hi_q;
    logic [`CART_ADDR_W-1:0] addr_q;
    logic                    merq_n_q;
    logic                    iorq_n_q;
    logic                    m1_n_q;

    logic [`SYNC_STAGES-1:0][2:0]              strb_sync;    // rd_n, wr_n, sltsl_n
    logic [`SYNC_STAGES-1:0][`CART_DATA_W-1:0] data_sync;

    function automatic logic [2:0] sel_code(input dot_phase_t ph);
        case (ph)
            PH_LO_SEL, PH_LO_SMP:   sel_code = `MSEL_LO;
            PH_HI_SEL, PH_HI_SMP:   sel_code = `MSEL_HI;
            PH_CTL_SEL, PH_CTL_SMP: sel_code = `MSEL_CTL;
            default:                sel_code = `MSEL_NONE;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // dot sequencer

    assign phase_d = dot_phase_t'(phase_q + 3'd1);    // wraps after PH_IDLE1

    // select is registered so the pins never glitch
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            phase_q <= PH_IDLE1;
            msel_q  <= `MSEL_NONE;
        end else begin
            phase_q <= phase_d;
            msel_q  <= sel_code(phase_d);
        end
    end

    assign msel_n = msel_q;

    //////////////////////////////////////////////////////////////////////
    // mux sampling, one cycle after each select

    always_ff @(posedge clk108_w) begin
        if (phase_q == PH_LO_SMP)
            lo_q <= mp;
        if (phase_q == PH_HI_SMP)
            hi_q <= mp;
        if (phase_q == PH_CTL_SMP)
            addr_q <= {hi_q, lo_q};    // whole address moves with the control byte
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            merq_n_q <= 1'b1;
            iorq_n_q <= 1'b1;
            m1_n_q   <= 1'b1;
        end else if (phase_q == PH_CTL_SMP) begin
            merq_n_q <= mp[`CTL_MERQ_BIT];
            iorq_n_q <= mp[`CTL_IORQ_BIT];
            m1_n_q   <= mp[`CTL_M1_BIT];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // strobe and data synchronisers

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w)
            strb_sync <= '1;    // strobes idle high
        else
            strb_sync <= {strb_sync[`SYNC_STAGES-2:0], rd_n, wr_n, sltsl_n};
    end

    always_ff @(posedge clk108_w) begin
        data_sync <= {data_sync[`SYNC_STAGES-2:0], cd_in};
    end

    always_comb begin
        bus.addr    = addr_q;
        bus.merq_n  = merq_n_q;
        bus.iorq_n  = iorq_n_q;
        bus.m1_n    = m1_n_q;
        bus.rd_n    = strb_sync[`SYNC_STAGES-1][2];
        bus.wr_n    = strb_sync[`SYNC_STAGES-1][1];
        bus.sltsl_n = strb_sync[`SYNC_STAGES-1][0];
        bus.data    = data_sync[`SYNC_STAGES-1];
    end

    // the board only decodes these four selects
    a_msel_legal: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        msel_q inside {`MSEL_LO, `MSEL_HI, `MSEL_CTL, `MSEL_NONE});

endmodule

// ==== verilog/cart_config.svh ====
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// cartridge bus widths
`define CART_ADDR_W     16
`define CART_DATA_W     8

// sd control register window in the cartridge slot
`define SDC_ENABLE      16'h7E00    // bit 0 opens the window
`define SDC_CMD         16'h7E01
`define SDC_STATUS      16'h7E02
`define SDC_SADDR       16'h7E03    // four bytes, lsb first
`define SDC_END         16'h7EFF
`define SDC_SECTOR_W    32

// dot sequencer mux selects, active low
`define MSEL_LO         3'b110      // address bits 7..0
`define MSEL_HI         3'b101      // address bits 15..8
`define MSEL_CTL        3'b011      // control byte
`define MSEL_NONE       3'b111

// bit positions inside the control byte
`define CTL_MERQ_BIT    0
`define CTL_IORQ_BIT    1
`define CTL_M1_BIT      7

`define SYNC_STAGES     2

`endif

// ==== verilog/cart_data_out.sv ====
`timescale 1ns/1ps
`include "cart_config.svh"

module cart_data_out
    import cart_pkg::*;
(
    input  logic                    clk108_w,
    input  logic                    ram_enabled_w,
    input  rd_resp_t                rd_resp,
    output logic [`CART_DATA_W-1:0] cd_out,
    output logic                    datadir
);

    logic                    hit_q;
    logic                    hit_start;
    logic [`CART_DATA_W-1:0] data_q;

    assign hit_start = rd_resp.hit && !hit_q;    // first cycle of a read

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w)
            hit_q <= 1'b0;
        else
            hit_q <= rd_resp.hit;
    end

    // freeze the byte for the rest of the read
    always_ff @(posedge clk108_w) begin
        if (hit_start)
            data_q <= rd_resp.data;
    end

    assign cd_out = hit_start ? rd_resp.data : data_q;

    // low drives the cartridge bus
    // stays low one cycle past the end of the hit
    assign datadir = !(rd_resp.hit || hit_q);

endmodule

// ==== verilog/cart_pkg.sv ====
`include "cart_config.svh"

package cart_pkg;

    // one bus frame, select then sample for each mux byte
    typedef enum logic [2:0] {
        PH_LO_SEL  = 3'd0,
        PH_LO_SMP  = 3'd1,
        PH_HI_SEL  = 3'd2,
        PH_HI_SMP  = 3'd3,
        PH_CTL_SEL = 3'd4,
        PH_CTL_SMP = 3'd5,
        PH_IDLE0   = 3'd6,
        PH_IDLE1   = 3'd7
    } dot_phase_t;

    typedef enum logic [1:0] {
        SD_OP_NONE  = 2'd0,
        SD_OP_READ  = 2'd1,
        SD_OP_WRITE = 2'd2,
        SD_OP_INIT  = 2'd3
    } sd_op_t;

    typedef struct packed {
        logic [`CART_ADDR_W-1:0] addr;    // published once per frame
        logic                    merq_n;
        logic                    iorq_n;
        logic                    m1_n;
        logic                    rd_n;    // synchronised strobes
        logic                    wr_n;
        logic                    sltsl_n;
        logic [`CART_DATA_W-1:0] data;
    } cart_bus_t;

    typedef struct packed {
        sd_op_t                   op;
        logic [`SDC_SECTOR_W-1:0] sector;
    } sd_cmd_t;

    typedef struct packed {
        logic                    hit;     // enabled window read in progress
        logic [`CART_DATA_W-1:0] data;
    } rd_resp_t;

endpackage

// ==== verilog/cart_top.sv ====
`timescale 1ns/1ps
`include "cart_config.svh"

module cart_top
    import cart_pkg::*;
(
    input  logic                    clk108_w,
    input  logic                    ram_enabled_w,
    input  logic [`CART_DATA_W-1:0] mp,
    input  logic                    rd_n,
    input  logic                    wr_n,
    input  logic                    sltsl_n,
    input  logic [`CART_DATA_W-1:0] cd_in,
    input  logic                    sd_ack,
    input  logic                    crc_error,
    input  logic                    timeout_error,
    output logic [2:0]              msel_n,
    output logic [`CART_DATA_W-1:0] cd_out,
    output logic                    datadir,
    output logic                    sd_req,
    output sd_cmd_t                 sd_cmd,
    output logic                    led
);

    cart_bus_t bus;
    rd_resp_t  rd_resp;

    bus_demux bus_demux_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .sltsl_n       (sltsl_n),
        .cd_in         (cd_in),
        .msel_n        (msel_n),
        .bus           (bus)
    );

    sdc_regs sdc_regs_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .bus           (bus),
        .sd_ack        (sd_ack),
        .crc_error     (crc_error),
        .timeout_error (timeout_error),
        .rd_resp       (rd_resp),
        .sd_req        (sd_req),
        .sd_cmd        (sd_cmd),
        .led           (led)
    );

    cart_data_out cart_data_out_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .rd_resp       (rd_resp),
        .cd_out        (cd_out),
        .datadir       (datadir)
    );

endmodule

// ==== verilog/sdc_regs.sv ====
`timescale 1ns/1ps
`include "cart_config.svh"

module sdc_regs
    import cart_pkg::*;
(
    input  logic      clk108_w,
    input  logic      ram_enabled_w,
    input  cart_bus_t bus,
    input  logic      sd_ack,
    input  logic      crc_error,
    input  logic      timeout_error,
    output rd_resp_t  rd_resp,
    output logic      sd_req,
    output sd_cmd_t   sd_cmd,
    output logic      led
);

    typedef enum logic [1:0] {
        HS_IDLE = 2'b00,
        HS_REQ  = 2'b01,    // req high until ack seen
        HS_REL  = 2'b10     // req low, wait for ack to drop
    } hs_state_t;

    hs_state_t                hs_q;
    logic                     en_q;
    logic [`SDC_SECTOR_W-1:0] sector_q;
    sd_cmd_t                  cmd_q;
    rd_resp_t                 resp_q;
    logic                     wr_n_q;

    logic                    mem_cyc;
    logic                    in_window;
    logic                    sel;
    logic                    wr_stb;
    logic                    busy;
    sd_op_t                  op_w;
    logic [`CART_DATA_W-1:0] rd_data;

    // plain memory cycle in our slot
    assign mem_cyc   = !bus.sltsl_n && !bus.merq_n && bus.iorq_n && bus.m1_n;
    assign in_window = (bus.addr >= `SDC_ENABLE) && (bus.addr <= `SDC_END);
    assign sel       = mem_cyc && en_q && in_window;
    // address is captured a frame ahead of the strobe on a real bus
    assign wr_stb    = mem_cyc && wr_n_q && !bus.wr_n;
    assign busy      = (hs_q != HS_IDLE);

    always_comb begin
        if (bus.data[0])
            op_w = SD_OP_READ;
        else if (bus.data[1])
            op_w = SD_OP_WRITE;
        else if (bus.data[7])
            op_w = SD_OP_INIT;
        else
            op_w = SD_OP_NONE;
    end

    //////////////////////////////////////////////////////////////////////
    // register writes

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            wr_n_q   <= 1'b1;
            en_q     <= 1'b0;
            sector_q <= '0;
        end else begin
            wr_n_q <= bus.wr_n;
            if (wr_stb && bus.addr == `SDC_ENABLE)
                en_q <= bus.data[0];    // reachable with the window closed
            if (wr_stb && sel) begin
                case (bus.addr)
                    `SDC_SADDR:          sector_q[7:0]   <= bus.data;
                    `SDC_SADDR + 16'd1:  sector_q[15:8]  <= bus.data;
                    `SDC_SADDR + 16'd2:  sector_q[23:16] <= bus.data;
                    `SDC_SADDR + 16'd3:  sector_q[31:24] <= bus.data;
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // four-phase req/ack master

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            hs_q  <= HS_IDLE;
            cmd_q <= '0;
        end else begin
            case (hs_q)
                HS_IDLE: begin
                    // commands while busy fall through here and are dropped
                    if (wr_stb && sel && bus.addr == `SDC_CMD && op_w != SD_OP_NONE) begin
                        cmd_q.op     <= op_w;
                        cmd_q.sector <= sector_q;
                        hs_q         <= HS_REQ;
                    end
                end
                HS_REQ:  if (sd_ack)  hs_q <= HS_REL;
                HS_REL:  if (!sd_ack) hs_q <= HS_IDLE;
                default: hs_q <= HS_IDLE;
            endcase
        end
    end

    assign sd_req = (hs_q == HS_REQ);
    assign sd_cmd = cmd_q;
    assign led    = busy;

    //////////////////////////////////////////////////////////////////////
    // read side

    always_comb begin
        case (bus.addr)
            `SDC_ENABLE:        rd_data = {7'b0, en_q};
            `SDC_STATUS:        rd_data = {busy, 5'b0, timeout_error, crc_error};
            `SDC_SADDR:         rd_data = sector_q[7:0];
            `SDC_SADDR + 16'd1: rd_data = sector_q[15:8];
            `SDC_SADDR + 16'd2: rd_data = sector_q[23:16];
            `SDC_SADDR + 16'd3: rd_data = sector_q[31:24];
            default:            rd_data = 8'hFF;
        endcase
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            resp_q <= '0;
        end else begin
            resp_q.hit  <= sel && !bus.rd_n;
            resp_q.data <= rd_data;
        end
    end

    assign rd_resp = resp_q;

    // req only drops once the engine has answered
    a_req_fall_after_ack: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        $fell(sd_req) |-> $past(sd_ack));

    // engine may sample the command at any point of the request
    a_cmd_stable: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        sd_req |=> !sd_req || $stable(sd_cmd));

endmodule
